//--- Makefile
TOP = datapathTb

.PHONY: all build lint clean

all: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

build:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f project.f

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir

//--- project.f
src/datapathPkg.sv
src/controlPkg.sv
src/memoryInterface.sv
src/registerFile.sv
src/aluUnit.sv
src/busMux.sv
src/datapath.sv
verif/datapathTb.sv

//--- src/aluUnit.sv
`timescale 1ns/1ps

module aluUnit
        import datapathPkg::*, controlPkg::*;
(
        input  logic       Clock,
        input  logic       reset,
        input  controlWord ctrl,
        input  dataWord    busData,
        output wideWord    zValue
);

        dataWord                     yReg;
        wideWord                     zReg;
        wideWord                     zNext;
        dataWord                     narrowResult;
        dataWord                     incremented;
        logic [4:0]                  shiftCount;
        logic signed [2*dataWidth-1:0] yWide;
        logic signed [2*dataWidth-1:0] busWide;
        logic signed [2*dataWidth-1:0] product;

        assign shiftCount = busData[4:0];
        assign incremented = busData + dataWord'(1);

        // operands widened with sign so the product keeps all 64 bits
        assign yWide = $signed(yReg);
        assign busWide = $signed(busData);
        assign product = yWide * busWide;

        // Y is the A operand, the bus is B
        always_comb begin
                case (ctrl.aluOp)
                        opAdd:   narrowResult = yReg + busData;
                        opSub:   narrowResult = yReg - busData;
                        opAnd:   narrowResult = yReg & busData;
                        opOr:    narrowResult = yReg | busData;
                        opShl:   narrowResult = yReg << shiftCount;
                        opShr:   narrowResult = yReg >> shiftCount;
                        opNeg:   narrowResult = -busData;
                        opNot:   narrowResult = ~busData;
                        default: narrowResult = '0;
                endcase
        end

        // incPc overrides whatever op is on the control word
        always_comb begin
                if (ctrl.incPc)
                        zNext = {{dataWidth{1'b0}}, incremented};
                else if (ctrl.aluOp == opMul)
                        zNext = product;
                else
                        zNext = {{dataWidth{1'b0}}, narrowResult};
        end

        always_ff @(posedge Clock) begin
                if (reset) begin
                        yReg <= '0;
                        zReg <= '0;
                end else begin
                        if (ctrl.loads.yIn)
                                yReg <= busData;
                        if (ctrl.loads.zIn)
                                zReg <= zNext;
                end
        end

        assign zValue = zReg;

        zLoadHasOp: assert property (@(posedge Clock) disable iff (reset)
                (ctrl.loads.zIn && !ctrl.incPc) |-> (ctrl.aluOp != opNone))
                else $error("Z loaded with no ALU operation selected");

endmodule

//--- src/busMux.sv
`timescale 1ns/1ps

module busMux
        import datapathPkg::*, controlPkg::*;
(
        input  controlWord ctrl,
        input  dataWord    regValues [numRegs],
        input  dataWord    hiValue,
        input  dataWord    loValue,
        input  wideWord    zValue,
        input  dataWord    pcValue,
        input  dataWord    mdrValue,
        input  dataWord    irValue,
        output dataWord    busData
);

        regIndex    regSel;
        sourceIndex srcSel;
        dataWord    constValue;

        // C field sign-extended from bit constFieldWidth-1
        assign constValue = {{(dataWidth-constFieldWidth){irValue[constFieldWidth-1]}},
                             irValue[constFieldWidth-1:0]};

        always_comb begin
                regSel = '0;
                for (int i = 0; i < numRegs; i++) begin
                        if (ctrl.sources.rOut[i])
                                regSel = regIndex'(i);
                end
        end

        // source encoder
        always_comb begin
                if (|ctrl.sources.rOut)
                        srcSel = {1'b0, regSel};
                else if (ctrl.sources.hiOut)
                        srcSel = srcHi;
                else if (ctrl.sources.loOut)
                        srcSel = srcLo;
                else if (ctrl.sources.zHighOut)
                        srcSel = srcZHigh;
                else if (ctrl.sources.zLowOut)
                        srcSel = srcZLow;
                else if (ctrl.sources.pcOut)
                        srcSel = srcPc;
                else if (ctrl.sources.mdrOut)
                        srcSel = srcMdr;
                else if (ctrl.sources.cOut)
                        srcSel = srcC;
                else
                        srcSel = srcNone;
        end

        // numbers 0..15 fall through to the general registers
        always_comb begin
                case (srcSel)
                        srcHi:    busData = hiValue;
                        srcLo:    busData = loValue;
                        srcZHigh: busData = zValue[2*dataWidth-1:dataWidth];
                        srcZLow:  busData = zValue[dataWidth-1:0];
                        srcPc:    busData = pcValue;
                        srcMdr:   busData = mdrValue;
                        srcC:     busData = constValue;
                        srcNone:  busData = '0;
                        default:  busData = regValues[regSel];
                endcase
        end

        // two drivers in one step means the sequencer is broken
        always_comb begin
                assert ($onehot0(ctrl.sources))
                        else $error("more than one bus source enabled");
        end

endmodule

//--- src/controlPkg.sv
package controlPkg;

        import datapathPkg::*;

        // out-enables of which at most one may be set in a cycle
        typedef struct packed {
                logic [numRegs-1:0] rOut;
                logic               hiOut;
                logic               loOut;
                logic               zHighOut;
                logic               zLowOut;
                logic               pcOut;
                logic               mdrOut;
                logic               cOut;
        } busSources;

        // single-cycle load strobes
        typedef struct packed {
                logic [numRegs-1:0] rIn;
                logic               hiIn;
                logic               loIn;
                logic               pcIn;
                logic               irIn;
                logic               marIn;
                logic               mdrIn;
                logic               yIn;
                logic               zIn;
        } loadEnables;

        // one control step that applies for exactly one clock
        typedef struct packed {
                busSources  sources;
                loadEnables loads;
                logic       read;
                logic       incPc;
                aluOpcode   aluOp;
        } controlWord;

endpackage

//--- src/datapath.sv
`timescale 1ns/1ps

module datapath
        import datapathPkg::*, controlPkg::*;
(
        input  logic       Clock,
        input  logic       reset,
        input  controlWord ctrl,
        input  dataWord    memDataIn,
        output dataWord    busData,
        output dataWord    memAddress
);

        dataWord mdrValue;
        dataWord regValues [numRegs];
        dataWord hiValue;
        dataWord loValue;
        dataWord pcValue;
        dataWord irValue;
        wideWord zValue;

        // input side with MDR and MAR
        memoryInterface u_memoryInterface (
                .Clock      (Clock),
                .reset      (reset),
                .ctrl       (ctrl),
                .memDataIn  (memDataIn),
                .busData    (busData),
                .mdrValue   (mdrValue),
                .memAddress (memAddress)
        );

        registerFile u_registerFile (
                .Clock     (Clock),
                .reset     (reset),
                .ctrl      (ctrl),
                .busData   (busData),
                .regValues (regValues),
                .hiValue   (hiValue),
                .loValue   (loValue),
                .pcValue   (pcValue),
                .irValue   (irValue)
        );

        aluUnit u_aluUnit (
                .Clock   (Clock),
                .reset   (reset),
                .ctrl    (ctrl),
                .busData (busData),
                .zValue  (zValue)
        );

        // output side and the only driver of the shared bus
        busMux u_busMux (
                .ctrl      (ctrl),
                .regValues (regValues),
                .hiValue   (hiValue),
                .loValue   (loValue),
                .zValue    (zValue),
                .pcValue   (pcValue),
                .mdrValue  (mdrValue),
                .irValue   (irValue),
                .busData   (busData)
        );

endmodule

//--- src/datapathPkg.sv
package datapathPkg;

        localparam int dataWidth = 32;

        typedef logic [dataWidth-1:0]   dataWord;
        typedef logic [2*dataWidth-1:0] wideWord;
        typedef logic [3:0]             regIndex;
        typedef logic [3:0]             aluOpcode;
        typedef logic [4:0]             sourceIndex;

        localparam int numRegs = 16;
        localparam int constFieldWidth = 19;

        // storage slots that follow R0..R15 in the register file
        localparam int numStored = numRegs + 4;
        localparam int slotHi = numRegs;
        localparam int slotLo = numRegs + 1;
        localparam int slotPc = numRegs + 2;
        localparam int slotIr = numRegs + 3;

        // bus source numbers above the general registers 0..15
        localparam sourceIndex srcHi    = 5'd16;
        localparam sourceIndex srcLo    = 5'd17;
        localparam sourceIndex srcZHigh = 5'd18;
        localparam sourceIndex srcZLow  = 5'd19;
        localparam sourceIndex srcPc    = 5'd20;
        localparam sourceIndex srcMdr   = 5'd21;
        localparam sourceIndex srcC     = 5'd22;
        localparam sourceIndex srcNone  = 5'd31;

        localparam aluOpcode opNone = 4'd0;
        localparam aluOpcode opAdd  = 4'd1;
        localparam aluOpcode opSub  = 4'd2;
        localparam aluOpcode opAnd  = 4'd3;
        localparam aluOpcode opOr   = 4'd4;
        localparam aluOpcode opShl  = 4'd5;
        localparam aluOpcode opShr  = 4'd6;
        localparam aluOpcode opNeg  = 4'd7;
        localparam aluOpcode opNot  = 4'd8;
        localparam aluOpcode opMul  = 4'd9;

endpackage

//--- src/memoryInterface.sv
`timescale 1ns/1ps

module memoryInterface
        import datapathPkg::*, controlPkg::*;
(
        input  logic       Clock,
        input  logic       reset,
        input  controlWord ctrl,
        input  dataWord    memDataIn,
        input  dataWord    busData,
        output dataWord    mdrValue,
        output dataWord    memAddress
);

        dataWord mdrReg;
        dataWord marReg;
        dataWord mdrNext;

        // read selects the memory side, otherwise MDR takes the bus
        assign mdrNext = ctrl.read ? memDataIn : busData;

        always_ff @(posedge Clock) begin
                if (reset) begin
                        mdrReg <= '0;
                        marReg <= '0;
                end else begin
                        if (ctrl.loads.mdrIn)
                                mdrReg <= mdrNext;
                        if (ctrl.loads.marIn)
                                marReg <= busData;
                end
        end

        assign mdrValue = mdrReg;
        assign memAddress = marReg;

        // a read with nowhere to land would lose the memory word
        readNeedsMdrIn: assert property (@(posedge Clock) disable iff (reset)
                ctrl.read |-> ctrl.loads.mdrIn)
                else $error("read asserted without mdrIn");

endmodule

//--- src/registerFile.sv
`timescale 1ns/1ps

module registerFile
        import datapathPkg::*, controlPkg::*;
(
        input  logic       Clock,
        input  logic       reset,
        input  controlWord ctrl,
        input  dataWord    busData,
        output dataWord    regValues [numRegs],
        output dataWord    hiValue,
        output dataWord    loValue,
        output dataWord    pcValue,
        output dataWord    irValue
);

        logic [numStored-1:0] strobes;
        dataWord              stored [numStored];

        // general registers first, then HI, LO, PC and IR in slot order
        assign strobes = {ctrl.loads.irIn, ctrl.loads.pcIn,
                          ctrl.loads.loIn, ctrl.loads.hiIn, ctrl.loads.rIn};

        always_ff @(posedge Clock) begin
                for (int i = 0; i < numStored; i++) begin
                        if (reset)
                                stored[i] <= '0;
                        else if (strobes[i])
                                stored[i] <= busData;
                end
        end

        always_comb begin
                for (int i = 0; i < numRegs; i++) begin
                        regValues[i] = stored[i];
                end
        end

        assign hiValue = stored[slotHi];
        assign loValue = stored[slotLo];
        assign pcValue = stored[slotPc];
        assign irValue = stored[slotIr];

endmodule

//--- verif/datapathTb.sv
`timescale 1ns/1ps

module datapathTb
        import datapathPkg::*, controlPkg::*;
();

        // R0..R15 followed by HI at 16 and LO at 17
        localparam int numLoadable = numRegs + 2;
        localparam int mulRounds = 4;
        localparam aluOpcode narrowOps [8] = '{opAdd, opSub, opAnd, opOr,
                                               opShl, opShr, opNeg, opNot};

        // cycles per test at one per control step
        localparam int resetCycles = 8;
        localparam int sourceCycles = $bits(busSources);
        localparam int loadCycles = numLoadable * 3;
        localparam int aluCycles = 8 * 8;
        localparam int mulCycles = mulRounds * 8;
        localparam int fetchCycles = 6;
        localparam int constCycles = 2 * 3;
        localparam int cycleLimit = 2 * (resetCycles + sourceCycles + loadCycles
                                         + aluCycles + mulCycles + fetchCycles
                                         + constCycles);

        logic       Clock = 1'b0;
        logic       reset;
        controlWord ctrl;
        dataWord    memDataIn;
        dataWord    busData;
        dataWord    memAddress;

        dataWord lfsrState = 32'h1b83_cd2f;
        dataWord modelStored [numLoadable];
        dataWord modelY;
        wideWord modelZ;
        int      cycleCount = 0;
        int      checkCount = 0;
        int      errorCount = 0;
        int      testCount = 0;
        int      failedTests = 0;

        datapath u_dut (
                .Clock      (Clock),
                .reset      (reset),
                .ctrl       (ctrl),
                .memDataIn  (memDataIn),
                .busData    (busData),
                .memAddress (memAddress)
        );

        always #2 Clock = ~Clock;

        always @(posedge Clock) begin
                cycleCount <= cycleCount + 1;
                if (cycleCount >= cycleLimit) begin
                        $display("timeout: run did not finish within %0d cycles", cycleLimit);
                        $display("Testbench failed");
                        $finish;
                end
        end

        // taps 32, 22, 2, 1
        function automatic dataWord lfsrStep(input dataWord s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        function automatic dataWord randomWord();
                dataWord value;
                value = '0;
                for (int i = 0; i < dataWidth; i++) begin
                        lfsrState = lfsrStep(lfsrState);
                        value = {value[dataWidth-2:0], lfsrState[0]};
                end
                return value;
        endfunction

        // Y is A, the bus is B; everything but MUL lands zero-extended
        function automatic wideWord expectedAlu(input aluOpcode op, input dataWord a,
                                                input dataWord b);
                wideWord extA;
                wideWord extB;
                dataWord result;
                extA = {{dataWidth{a[dataWidth-1]}}, a};
                extB = {{dataWidth{b[dataWidth-1]}}, b};
                case (op)
                        opAdd:   result = a + b;
                        opSub:   result = a - b;
                        opAnd:   result = a & b;
                        opOr:    result = a | b;
                        opShl:   result = a << b[4:0];
                        opShr:   result = a >> b[4:0];
                        opNeg:   result = ~b + 32'd1;
                        opNot:   result = ~b;
                        default: result = '0;
                endcase
                if (op == opMul)
                        return extA * extB;
                else
                        return {{dataWidth{1'b0}}, result};
        endfunction

        function automatic dataWord constOf(input dataWord ir);
                dataWord value;
                value = dataWord'(ir[constFieldWidth-1:0]);
                if (ir[constFieldWidth-1])
                        value = value - (dataWord'(1) << constFieldWidth);
                return value;
        endfunction

        function automatic loadEnables regLoad(input int i);
                loadEnables l;
                l = '0;
                if (i < numRegs)
                        l.rIn[i] = 1'b1;
                else if (i == numRegs)
                        l.hiIn = 1'b1;
                else
                        l.loIn = 1'b1;
                return l;
        endfunction

        function automatic busSources regSource(input int i);
                busSources s;
                s = '0;
                if (i < numRegs)
                        s.rOut[i] = 1'b1;
                else if (i == numRegs)
                        s.hiOut = 1'b1;
                else
                        s.loOut = 1'b1;
                return s;
        endfunction

        // one control step with outputs sampled at the following falling edge
        task automatic applyStep(input controlWord cw, input dataWord data);
                @(posedge Clock);
                ctrl <= cw;
                memDataIn <= data;
                @(negedge Clock);
        endtask

        task automatic checkBus(input dataWord expected, input string what);
                checkCount++;
                busMatches: assert (busData === expected)
                else begin
                        $display("mismatch at %0t: busData (%s) expected %h, got %h",
                                 $time, what, expected, busData);
                        errorCount++;
                end
        endtask

        task automatic checkAddress(input dataWord expected);
                checkCount++;
                addressMatches: assert (memAddress === expected)
                else begin
                        $display("mismatch at %0t: memAddress expected %h, got %h",
                                 $time, expected, memAddress);
                        errorCount++;
                end
        endtask

        task automatic loadViaMdr(input dataWord value, input loadEnables target);
                controlWord cw;
                cw = '0;
                cw.read = 1'b1;
                cw.loads.mdrIn = 1'b1;
                applyStep(cw, value);
                cw = '0;
                cw.sources.mdrOut = 1'b1;
                cw.loads = target;
                applyStep(cw, '0);
                checkBus(value, "MDR");
        endtask

        // R3 into Y, then Y op R7 into Z
        task automatic runOperation(input aluOpcode op, input dataWord a, input dataWord b);
                controlWord cw;
                loadViaMdr(a, regLoad(3));
                modelStored[3] = a;
                loadViaMdr(b, regLoad(7));
                modelStored[7] = b;
                cw = '0;
                cw.sources.rOut[3] = 1'b1;
                cw.loads.yIn = 1'b1;
                applyStep(cw, '0);
                modelY = modelStored[3];
                cw = '0;
                cw.sources.rOut[7] = 1'b1;
                cw.loads.zIn = 1'b1;
                cw.aluOp = op;
                applyStep(cw, '0);
                modelZ = expectedAlu(op, modelY, modelStored[7]);
        endtask

        task automatic finishTest(input string name, input int errorsAtStart);
                testCount++;
                if (errorCount == errorsAtStart) begin
                        $display("test %s: ok", name);
                end else begin
                        failedTests++;
                        $display("test %s: %0d mismatches", name, errorCount - errorsAtStart);
                end
        endtask

        task automatic resetTest();
                controlWord                   cw;
                logic [$bits(busSources)-1:0] oneHot;
                int                           errorsAtStart;
                errorsAtStart = errorCount;
                for (int n = 0; n < $bits(busSources); n++) begin
                        oneHot = '0;
                        oneHot[n] = 1'b1;
                        cw = '0;
                        cw.sources = oneHot;
                        applyStep(cw, '0);
                        checkBus('0, $sformatf("source bit %0d", n));
                        checkAddress('0);
                end
                finishTest("reset", errorsAtStart);
        endtask

        task automatic registerLoadTest();
                controlWord cw;
                int         errorsAtStart;
                errorsAtStart = errorCount;
                for (int i = 0; i < numLoadable; i++) begin
                        modelStored[i] = randomWord();
                        loadViaMdr(modelStored[i], regLoad(i));
                end
                // read back only after all are loaded, so a stray strobe shows up
                for (int i = 0; i < numLoadable; i++) begin
                        cw = '0;
                        cw.sources = regSource(i);
                        applyStep(cw, '0);
                        checkBus(modelStored[i], $sformatf("register %0d", i));
                end
                finishTest("registers", errorsAtStart);
        endtask

        task automatic aluTest();
                controlWord cw;
                int         errorsAtStart;
                errorsAtStart = errorCount;
                foreach (narrowOps[k]) begin
                        runOperation(narrowOps[k], randomWord(), randomWord());
                        cw = '0;
                        cw.sources.zLowOut = 1'b1;
                        cw.loads.rIn[4] = 1'b1;
                        applyStep(cw, '0);
                        checkBus(modelZ[dataWidth-1:0], $sformatf("ZLow op %0d", narrowOps[k]));
                        modelStored[4] = modelZ[dataWidth-1:0];
                        cw = '0;
                        cw.sources.rOut[4] = 1'b1;
                        applyStep(cw, '0);
                        checkBus(modelStored[4], $sformatf("R4 op %0d", narrowOps[k]));
                end
                finishTest("alu", errorsAtStart);
        endtask

        task automatic mulTest();
                controlWord cw;
                int         errorsAtStart;
                errorsAtStart = errorCount;
                for (int k = 0; k < mulRounds; k++) begin
                        runOperation(opMul, randomWord(), randomWord());
                        cw = '0;
                        cw.sources.zHighOut = 1'b1;
                        applyStep(cw, '0);
                        checkBus(modelZ[2*dataWidth-1:dataWidth], "ZHigh");
                        cw = '0;
                        cw.sources.zLowOut = 1'b1;
                        applyStep(cw, '0);
                        checkBus(modelZ[dataWidth-1:0], "ZLow");
                end
                finishTest("mul", errorsAtStart);
        endtask

        task automatic fetchTest();
                controlWord cw;
                loadEnables pcLoad;
                dataWord    oldPc;
                dataWord    instr;
                int         errorsAtStart;
                errorsAtStart = errorCount;
                oldPc = randomWord();
                instr = randomWord();
                pcLoad = '0;
                pcLoad.pcIn = 1'b1;
                loadViaMdr(oldPc, pcLoad);
                cw = '0;
                cw.sources.pcOut = 1'b1;
                cw.loads.marIn = 1'b1;
                cw.loads.zIn = 1'b1;
                cw.incPc = 1'b1;
                applyStep(cw, '0);
                checkBus(oldPc, "PC out");
                // memory answers while the incremented PC goes back
                cw = '0;
                cw.sources.zLowOut = 1'b1;
                cw.loads.pcIn = 1'b1;
                cw.read = 1'b1;
                cw.loads.mdrIn = 1'b1;
                applyStep(cw, instr);
                checkBus(oldPc + 32'd1, "ZLow after IncPC");
                checkAddress(oldPc);
                cw = '0;
                cw.sources.mdrOut = 1'b1;
                cw.loads.irIn = 1'b1;
                applyStep(cw, '0);
                checkBus(instr, "MDR to IR");
                cw = '0;
                cw.sources.pcOut = 1'b1;
                applyStep(cw, '0);
                checkBus(oldPc + 32'd1, "new PC");
                checkAddress(oldPc);
                finishTest("fetch", errorsAtStart);
        endtask

        task automatic constantTest();
                controlWord cw;
                loadEnables irLoad;
                dataWord    ir;
                int         errorsAtStart;
                errorsAtStart = errorCount;
                irLoad = '0;
                irLoad.irIn = 1'b1;
                for (int k = 0; k < 2; k++) begin
                        ir = randomWord();
                        ir[constFieldWidth-1] = (k == 1);
                        loadViaMdr(ir, irLoad);
                        cw = '0;
                        cw.sources.cOut = 1'b1;
                        applyStep(cw, '0);
                        checkBus(constOf(ir), k == 1 ? "C negative" : "C positive");
                end
                finishTest("constant", errorsAtStart);
        endtask

        initial begin
                ctrl = '0;
                memDataIn = '0;
                reset = 1'b1;
                repeat (resetCycles) @(posedge Clock);
                reset <= 1'b0;
                resetTest();
                registerLoadTest();
                aluTest();
                mulTest();
                fetchTest();
                constantTest();
                $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
                         testCount, failedTests, checkCount, errorCount);
                if (errorCount == 0 && failedTests == 0)
                        $display("Testbench passed");
                else
                        $display("Testbench failed");
                $finish;
        end

endmodule
